// ==== all.f ====
src/exec_pkg.sv
src/int_alu.sv
src/cond_eval.sv
src/result_merge.sv
src/exec_unit.sv
testbench/exec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module exec_unit_tb -o exec_sim \
  && ./obj_dir/exec_sim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== src/cond_eval.sv ====
`default_nettype none

module cond_eval
  import exec_pkg::*;
(
  input  logic      clk,
  input  exec_req_t req,
  output cond_res_t cond_q
);

  flags_t f;
  logic   n_eq_v;   // signed compare helper
  logic   pass;

  assign f      = req.flags;
  assign n_eq_v = (f.n == f.v);

  // runs every cycle since it only matters next to a valid alu_q
  always_comb begin
    case (req.cond)
      cond_eq: pass = f.z;
      cond_ne: pass = !f.z;
      cond_cs: pass = f.c;
      cond_cc: pass = !f.c;
      cond_mi: pass = f.n;
      cond_pl: pass = !f.n;
      cond_vs: pass = f.v;
      cond_vc: pass = !f.v;
      cond_hi: pass = f.c && !f.z;   // unsigned higher
      cond_ls: pass = !f.c || f.z;
      cond_ge: pass = n_eq_v;
      cond_lt: pass = !n_eq_v;
      cond_gt: pass = !f.z && n_eq_v;
      cond_le: pass = f.z || !n_eq_v;
      cond_al: pass = 1'b1;
      default: pass = 1'b0;          // nv
    endcase
  end

  always_ff @(posedge clk) begin
    cond_q.pass      <= pass;
    cond_q.old_flags <= req.flags;  // kept for the not taken case
  end

  a_al_passes: assert property (
    @(posedge clk)
    req.cond == cond_al |=> cond_q.pass
  );

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int DATA_W  = 64;
  localparam int SHAMT_W = 6;   // low bits of b used by the shifts
  localparam int TAG_W   = 6;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,   // a + ~b + 1
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_sra = 4'd7,
    op_mov = 4'd8    // passes b
  } alu_op_t;

  // condition codes evaluated on the incoming flags
  typedef enum logic [3:0] {
    cond_eq = 4'd0,   // z
    cond_ne = 4'd1,   // !z
    cond_cs = 4'd2,   // c
    cond_cc = 4'd3,   // !c
    cond_mi = 4'd4,   // n
    cond_pl = 4'd5,   // !n
    cond_vs = 4'd6,   // v
    cond_vc = 4'd7,   // !v
    cond_hi = 4'd8,   // c & !z
    cond_ls = 4'd9,   // !c | z
    cond_ge = 4'd10,  // n == v
    cond_lt = 4'd11,  // n != v
    cond_gt = 4'd12,  // !z & n == v
    cond_le = 4'd13,  // z | n != v
    cond_al = 4'd14,
    cond_nv = 4'd15
  } cond_t;

  typedef struct packed {
    logic c;  // carry out means no borrow on sub
    logic v;  // signed overflow
    logic n;
    logic z;
  } flags_t;

  typedef struct packed {
    logic    valid;
    alu_op_t op;
    cond_t   cond;
    flags_t  flags;  // current flags
    data_t   a;
    data_t   b;
    tag_t    tag;
  } exec_req_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
    logic  carry;
    logic  overflow;
  } alu_res_t;

  typedef struct packed {
    logic   pass;
    flags_t old_flags;  // request flags one cycle late
  } cond_res_t;

  typedef struct packed {
    logic   valid;
    logic   taken;
    tag_t   tag;
    data_t  value;
    flags_t flags;
  } exec_resp_t;

endpackage

`default_nettype wire

// ==== src/exec_unit.sv ====
`default_nettype none

module exec_unit
  import exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  exec_req_t  req,
  output exec_resp_t resp
);

  alu_res_t  alu_q;   // value, carry, overflow one cycle after req
  cond_res_t cond_q;  // condition result in step with alu_q

  int_alu u_int_alu (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .alu_q (alu_q)
  );

  // condition checked alongside the alu
  cond_eval u_cond_eval (
    .clk    (clk),
    .req    (req),
    .cond_q (cond_q)
  );

  result_merge u_result_merge (
    .clk    (clk),
    .rst    (rst),
    .alu_q  (alu_q),
    .cond_q (cond_q),
    .resp   (resp)
  );

endmodule

`default_nettype wire

// ==== src/int_alu.sv ====
`default_nettype none

module int_alu
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  exec_req_t req,
  output alu_res_t  alu_q
);

  logic               is_sub;
  data_t              b_eff;
  logic [DATA_W:0]    sum;       // top bit is the carry out
  logic [SHAMT_W-1:0] shamt;
  logic               sign_a;
  logic               sign_b;
  logic               add_ovf;
  data_t              value;
  logic               carry;
  logic               overflow;

  assign is_sub = (req.op == op_sub);
  assign b_eff  = is_sub ? ~req.b : req.b;
  assign sum    = {1'b0, req.a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, is_sub};
  assign shamt  = req.b[SHAMT_W-1:0];

  // same operand signs but the result sign differs
  assign sign_a  = req.a[DATA_W-1];
  assign sign_b  = b_eff[DATA_W-1];
  assign add_ovf = (sign_a == sign_b) && (sum[DATA_W-1] != sign_a);

  always_comb begin
    value    = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (req.op)
      op_add,
      op_sub: begin
        value    = sum[DATA_W-1:0];
        carry    = sum[DATA_W];
        overflow = add_ovf;
      end
      op_and: begin
        value = req.a & req.b;
      end
      op_or: begin
        value = req.a | req.b;
      end
      op_xor: begin
        value = req.a ^ req.b;
      end
      op_sll: begin
        value = req.a << shamt;
      end
      op_srl: begin
        value = req.a >> shamt;
      end
      op_sra: begin
        value = data_t'($signed(req.a) >>> shamt);
      end
      op_mov: begin
        value = req.b;
      end
      default: begin
        value = '0;  // undefined op
      end
    endcase
  end

  always_ff @(posedge clk) begin
    alu_q.tag      <= req.tag;
    alu_q.value    <= value;
    alu_q.carry    <= carry;
    alu_q.overflow <= overflow;
    if (rst) begin
      alu_q.valid <= 1'b0;
    end else begin
      alu_q.valid <= req.valid;
    end
  end

  // nine defined opcodes only
  a_legal_op: assert property (
    @(posedge clk) disable iff (rst)
    req.valid |-> req.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                 op_sll, op_srl, op_sra, op_mov}
  );

  a_valid_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(alu_q.valid)
  );

endmodule

`default_nettype wire

// ==== src/result_merge.sv ====
`default_nettype none

module result_merge
  import exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  alu_res_t   alu_q,
  input  cond_res_t  cond_q,
  output exec_resp_t resp
);

  flags_t new_flags;
  flags_t next_flags;

  // flags produced by this result
  always_comb begin
    new_flags.c = alu_q.carry;
    new_flags.v = alu_q.overflow;
    new_flags.n = alu_q.value[DATA_W-1];
    new_flags.z = (alu_q.value == '0);
  end

  // flags stay as they came in when the condition fails
  assign next_flags = cond_q.pass ? new_flags : cond_q.old_flags;

  always_ff @(posedge clk) begin
    resp.taken <= cond_q.pass;
    resp.tag   <= alu_q.tag;
    resp.value <= alu_q.value;  // meaningless when not taken
    resp.flags <= next_flags;
    if (rst) begin
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= alu_q.valid;
    end
  end

  // old flags travel two stages without change
  a_keep_flags: assert property (
    @(posedge clk) disable iff (rst)
    resp.valid && !resp.taken |-> resp.flags == $past(cond_q.old_flags)
  );

endmodule

`default_nettype wire

// ==== testbench/exec_input.txt ====
# op cond flags a b tag, then expected taken value flags; all hex
# flags digit bits: 3 c, 2 v, 1 n, 0 z; value is ignored when not taken
0 e 0 0000000000000005 0000000000000003 01 1 0000000000000008 0
0 e 0 ffffffffffffffff 0000000000000001 02 1 0000000000000000 9
0 e 0 7fffffffffffffff 0000000000000001 03 1 8000000000000000 6
0 e 0 8000000000000000 8000000000000000 04 1 0000000000000000 d
0 e 0 0000000000000001 fffffffffffffffe 05 1 ffffffffffffffff 2
0 e 0 ffffffffffffffff ffffffffffffffff 06 1 fffffffffffffffe a
0 e 0 1111111111111111 2222222222222222 07 1 3333333333333333 0
1 e 0 000000000000000a 0000000000000003 08 1 0000000000000007 8
1 e 0 0000000000000005 0000000000000005 09 1 0000000000000000 9
1 e 0 0000000000000003 0000000000000005 0a 1 fffffffffffffffe 2
1 e 0 8000000000000000 0000000000000001 0b 1 7fffffffffffffff c
1 e 0 7fffffffffffffff ffffffffffffffff 0c 1 8000000000000000 6
1 e 0 1234567890abcdef 0fedcba987654321 0d 1 02468acf09468ace 8
2 e f f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0e 1 f000f000f000f000 2
2 e f 00ff00ff00ff00ff ff00ff00ff00ff00 0f 1 0000000000000000 1
3 e f 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 10 1 0fff0fff0fff0fff 0
3 e 0 8000000000000000 0000000000000001 11 1 8000000000000001 2
4 e f aaaaaaaaaaaaaaaa ffffffffffffffff 12 1 5555555555555555 0
4 e f 123456789abcdef0 123456789abcdef0 13 1 0000000000000000 1
5 e f 8000000000000001 0000000000000000 14 1 8000000000000001 2
5 e 0 0123456789abcdef 0000000000000004 15 1 123456789abcdef0 0
5 e f 0000000000000003 000000000000003f 16 1 8000000000000000 2
5 e 0 0000000000000001 ffffffffffffff04 17 1 0000000000000010 0
6 e f 8000000000000000 0000000000000001 18 1 4000000000000000 0
6 e 0 ffffffffffffffff 000000000000003f 19 1 0000000000000001 0
6 e f fedcba9876543210 0000000000000000 1a 1 fedcba9876543210 2
6 e 0 0000000000000001 0000000000000001 1b 1 0000000000000000 1
6 e f f000000000000000 0000000000000104 1c 1 0f00000000000000 0
7 e 0 f000000000000000 0000000000000004 1d 1 ff00000000000000 2
7 e f 8000000000000000 000000000000003f 1e 1 ffffffffffffffff 2
7 e 0 7000000000000000 0000000000000004 1f 1 0700000000000000 0
7 e f 8000000000000000 0000000000000000 20 1 8000000000000000 2
7 e 0 8000000000000000 ffffffffffffffc8 21 1 ff80000000000000 2
8 e f ffffffffffffffff 0123456789abcdef 22 1 0123456789abcdef 0
8 e f 5555555555555555 0000000000000000 23 1 0000000000000000 1
8 e 0 0000000000000000 8000000000000000 24 1 8000000000000000 2
0 0 1 ffffffffffffffff 0000000000000001 25 1 0000000000000000 9
0 0 0 ffffffffffffffff 0000000000000001 26 0 0000000000000000 0
0 1 0 ffffffffffffffff 0000000000000001 27 1 0000000000000000 9
0 1 1 ffffffffffffffff 0000000000000001 28 0 0000000000000000 1
0 2 8 ffffffffffffffff 0000000000000001 29 1 0000000000000000 9
0 2 7 ffffffffffffffff 0000000000000001 2a 0 0000000000000000 7
0 3 0 ffffffffffffffff 0000000000000001 2b 1 0000000000000000 9
0 3 8 ffffffffffffffff 0000000000000001 2c 0 0000000000000000 8
0 4 2 ffffffffffffffff 0000000000000001 2d 1 0000000000000000 9
0 4 d ffffffffffffffff 0000000000000001 2e 0 0000000000000000 d
0 5 0 ffffffffffffffff 0000000000000001 2f 1 0000000000000000 9
0 5 2 ffffffffffffffff 0000000000000001 30 0 0000000000000000 2
0 6 4 ffffffffffffffff 0000000000000001 31 1 0000000000000000 9
0 6 b ffffffffffffffff 0000000000000001 32 0 0000000000000000 b
0 7 0 ffffffffffffffff 0000000000000001 33 1 0000000000000000 9
0 7 4 ffffffffffffffff 0000000000000001 34 0 0000000000000000 4
0 8 8 ffffffffffffffff 0000000000000001 35 1 0000000000000000 9
0 8 d ffffffffffffffff 0000000000000001 36 0 0000000000000000 d
0 9 0 ffffffffffffffff 0000000000000001 38 1 0000000000000000 9
0 9 9 ffffffffffffffff 0000000000000001 39 1 0000000000000000 9
0 9 8 ffffffffffffffff 0000000000000001 3a 0 0000000000000000 8
0 a 0 ffffffffffffffff 0000000000000001 3b 1 0000000000000000 9
0 a 6 ffffffffffffffff 0000000000000001 3c 1 0000000000000000 9
0 a 2 ffffffffffffffff 0000000000000001 3d 0 0000000000000000 2
0 a 4 ffffffffffffffff 0000000000000001 3e 0 0000000000000000 4
0 b 2 ffffffffffffffff 0000000000000001 3f 1 0000000000000000 9
0 b 4 ffffffffffffffff 0000000000000001 00 1 0000000000000000 9
0 b 0 ffffffffffffffff 0000000000000001 01 0 0000000000000000 0
0 b 6 ffffffffffffffff 0000000000000001 02 0 0000000000000000 6
0 c 0 ffffffffffffffff 0000000000000001 03 1 0000000000000000 9
0 c 6 ffffffffffffffff 0000000000000001 04 1 0000000000000000 9
0 c 1 ffffffffffffffff 0000000000000001 05 0 0000000000000000 1
0 c 2 ffffffffffffffff 0000000000000001 06 0 0000000000000000 2
0 d 1 ffffffffffffffff 0000000000000001 07 1 0000000000000000 9
0 d 2 ffffffffffffffff 0000000000000001 08 1 0000000000000000 9
0 d 0 ffffffffffffffff 0000000000000001 09 0 0000000000000000 0
0 d 6 ffffffffffffffff 0000000000000001 0a 0 0000000000000000 6
0 e f ffffffffffffffff 0000000000000001 0b 1 0000000000000000 9
0 f f ffffffffffffffff 0000000000000001 0c 0 0000000000000000 f
0 f 0 ffffffffffffffff 0000000000000001 0d 0 0000000000000000 0
1 0 0 0000000000000005 0000000000000005 0e 0 0000000000000000 0

// ==== testbench/exec_unit_tb.sv ====
`default_nettype none

module exec_unit_tb
  import exec_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 2;  // ns after the rising edge
  localparam int LATENCY      = 2;  // cycles from drive to resp

  typedef struct packed {
    exec_req_t req;
    logic      taken;
    data_t     value;
    flags_t    flags;
  } vector_t;

  typedef struct {
    logic   taken;
    tag_t   tag;
    data_t  value;
    flags_t flags;
    int     due;      // cycle count when resp must show up
    int     line_no;
  } expect_t;

  logic       clk;
  logic       rst;
  exec_req_t  req;
  exec_resp_t resp;
  int         cycle = 0;
  int         cycle_limit = 0;
  vector_t    vectors[$];
  int         vec_line[$];
  expect_t    pending[$];

  exec_unit DUT (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .resp (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s value: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_flags(input string name, input flags_t expected, input flags_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s flags cvnz: expected %b, actual %b",
                                  name, expected, actual));
    end
  endtask

  task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s tag: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_taken(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s taken: expected %b, actual %b",
                                  name, expected, actual));
    end
  endtask

  task automatic check_cycle(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_with_failure($sformatf("[FAIL] %s arrival cycle: expected %0d, actual %0d",
                                  name, expected, actual));
    end
  endtask

  task automatic load_vectors();
    int         fd;
    int         n;
    int         line_no;
    string      line;
    logic [3:0] op_raw;
    logic [3:0] cond_raw;
    logic [3:0] flags_raw;
    logic [3:0] exp_flags_raw;
    data_t      a;
    data_t      b;
    data_t      value;
    tag_t       tag;
    logic       taken;
    vector_t    v;
    fd = $fopen("testbench/exec_input.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open testbench/exec_input.txt");
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0) break;
      line_no++;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // header or blank
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op_raw, cond_raw, flags_raw,
                  a, b, tag, taken, value, exp_flags_raw);
      if (n != 9) begin
        stop_with_failure($sformatf("input file line %0d is not a valid vector", line_no));
      end
      v.req.valid = 1'b1;
      v.req.op    = alu_op_t'(op_raw);
      v.req.cond  = cond_t'(cond_raw);
      v.req.flags = flags_t'(flags_raw);
      v.req.a     = a;
      v.req.b     = b;
      v.req.tag   = tag;
      v.taken     = taken;
      v.value     = value;
      v.flags     = flags_t'(exp_flags_raw);
      vectors.push_back(v);
      vec_line.push_back(line_no);
    end
    $fclose(fd);
  endtask

  // cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      stop_with_failure($sformatf("timeout after %0d cycles with %0d responses outstanding",
                                  cycle, pending.size()));
    end
  end

  // resp is stable at the falling edge
  initial begin
    expect_t e;
    string   name;
    forever begin
      @(negedge clk);
      if (resp.valid === 1'b1) begin
        if (pending.size() == 0) begin
          stop_with_failure("a valid response came out with no request outstanding");
        end
        e = pending.pop_front();
        name = $sformatf("line %0d", e.line_no);
        check_cycle(name, e.due, cycle);
        check_tag(name, e.tag, resp.tag);
        check_taken(name, e.taken, resp.taken);
        if (e.taken) begin
          check_value(name, e.value, resp.value);
        end
        check_flags(name, e.flags, resp.flags);
      end else if (resp.valid !== 1'b0) begin
        stop_with_failure("resp.valid is unknown");
      end
    end
  end

  initial begin
    int      gap;
    expect_t e;
    void'($urandom(89334));
    req = '0;
    rst = 1'b1;
    load_vectors();
    cycle_limit = vectors.size() * 4 + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    foreach (vectors[i]) begin
      // first half back to back then random idle gaps
      gap = (i < vectors.size() / 2) ? 0 : int'($urandom % 4);
      repeat (gap) begin
        @(posedge clk);
        #DRIVE_DELAY;
        req = '0;
      end
      @(posedge clk);
      #DRIVE_DELAY;
      req = vectors[i].req;
      e.taken   = vectors[i].taken;
      e.tag     = vectors[i].req.tag;
      e.value   = vectors[i].value;
      e.flags   = vectors[i].flags;
      e.due     = cycle + LATENCY;
      e.line_no = vec_line[i];
      pending.push_back(e);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    req = '0;

    // room for the last response and for a stray one after it
    repeat (LATENCY + 3) @(posedge clk);

    if (pending.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d expected responses never came out",
                                  pending.size()));
    end
  end

endmodule

`default_nettype wire
